//--- hdl/sd_cmd_pkg.sv
/*
  Shared definitions for the SD command channel
  Command, response and length widths
  CRC7 size and feedback taps
  Controller state encoding
*/

package sd_cmd_pkg;

  // Command word as held by the host, MSB goes out first
  localparam int CMD_W = 40;

  // Capture register, wide enough for an R2 response
  localparam int RSP_W = 136;

  // Host length ports
  localparam int LEN_W = 8;

  // CRC7 over the CMD line
  localparam int CRC_W = 7;

  // x^7 + x^3 + 1, the x^7 term is implied by the shift
  localparam logic [CRC_W-1:0] CRC7_POLY = 7'h09;

  // Bit counters in the serializer and the receiver
  localparam int CNT_W = 8;

  // Controller phases
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SEND,
    ST_RECV,
    ST_DONE
  } cmd_state_t;

endpackage

//--- hdl/sd_cmd_if.sv
/*
  Links between the command controller and its workers
  cmd_tx_if: controller to command serializer
  rsp_rx_if: controller to response receiver
*/
`timescale 1ns/1ps

interface cmd_tx_if;
  import sd_cmd_pkg::*;

  logic             start;
  logic             abort;
  logic [CMD_W-1:0] cmd;
  logic [LEN_W-1:0] cmd_len;
  logic             done;

  // Start only while the serializer is idle, one done per start
  modport ctrl (
    output start, abort, cmd, cmd_len,
    input  done
  );

  modport worker (
    input  start, abort, cmd, cmd_len,
    output done
  );
endinterface

interface rsp_rx_if;
  import sd_cmd_pkg::*;

  logic             start;
  logic             abort;
  logic [LEN_W-1:0] rsp_len;
  logic             done;
  logic [RSP_W-1:0] rsp;
  logic             crc_err;

  // rsp and crc_err are valid in the done cycle
  modport ctrl (
    output start, abort, rsp_len,
    input  done, rsp, crc_err
  );

  modport worker (
    input  start, abort, rsp_len,
    output done, rsp, crc_err
  );
endinterface

//--- hdl/sd_crc_7.sv
/*
  Bit-serial CRC7 for the SD CMD line
  Clear and enable together start a new CRC with the current bit
*/
`timescale 1ns/1ps

module sd_crc_7 (
  input  logic                         i_sd_clk,
  input  logic                         i_clear,
  input  logic                         i_en,
  input  logic                         i_bit,
  output logic [sd_cmd_pkg::CRC_W-1:0] o_crc
);
  import sd_cmd_pkg::*;

  logic [CRC_W-1:0] base;
  logic             fb;

  // Start value for this step
  always_comb begin
    base = i_clear ? '0 : o_crc;
    fb   = i_bit ^ base[CRC_W-1];
  end

  always_ff @(posedge i_sd_clk) begin
    if (i_en) begin
      o_crc <= {base[CRC_W-2:0], 1'b0} ^ ({CRC_W{fb}} & CRC7_POLY);
    end else if (i_clear) begin
      o_crc <= '0;
    end
  end

endmodule

//--- hdl/sd_cmd_tx.sv
/*
  Command serializer for the SD CMD line
  Shifts out the leading command bits MSB first,
  then their CRC7 and one end bit
*/
`timescale 1ns/1ps

module sd_cmd_tx (
  input  logic     i_sd_clk,
  input  logic     rst,
  cmd_tx_if.worker tx,
  output logic     o_sd_cmd
);
  import sd_cmd_pkg::*;

  localparam int CRC_IW = $clog2(CRC_W);

  typedef enum logic [1:0] {TX_IDLE, TX_CMD, TX_CRC, TX_END} tx_state_t;

  tx_state_t        state;
  logic [CNT_W-1:0] cnt;
  logic [CMD_W-1:0] shreg;
  logic [CRC_W-1:0] crc;
  logic             load;
  logic             crc_en;
  logic             crc_bit;

  assign load = (state == TX_IDLE) && tx.start;

  // CRC follows each command bit as it goes out
  assign crc_en  = (load && (tx.cmd_len != '0)) || ((state == TX_CMD) && (cnt != CNT_W'(1)));
  assign crc_bit = load ? tx.cmd[CMD_W-1] : shreg[CMD_W-1];

  sd_crc_7 u_crc (
    .i_sd_clk (i_sd_clk),
    .i_clear  (load),
    .i_en     (crc_en),
    .i_bit    (crc_bit),
    .o_crc    (crc)
  );

  always_ff @(posedge i_sd_clk) begin
    if (load) begin
      shreg <= {tx.cmd[CMD_W-2:0], 1'b0};
    end else if (state == TX_CMD) begin
      shreg <= {shreg[CMD_W-2:0], 1'b0};
    end
  end

  always_ff @(posedge i_sd_clk) begin
    tx.done <= 1'b0;
    if (rst) begin
      state    <= TX_IDLE;
      cnt      <= '0;
      o_sd_cmd <= 1'b1;
    end else if (tx.abort) begin
      state    <= TX_IDLE;
      o_sd_cmd <= 1'b1;
    end else begin
      case (state)
        TX_IDLE: begin
          o_sd_cmd <= 1'b1;
          if (tx.start) begin
            if (tx.cmd_len != '0) begin
              o_sd_cmd <= tx.cmd[CMD_W-1];
              cnt      <= tx.cmd_len;
              state    <= TX_CMD;
            end else begin
              // Empty command, CRC of nothing is zero
              o_sd_cmd <= 1'b0;
              cnt      <= CNT_W'(CRC_W - 2);
              state    <= TX_CRC;
            end
          end
        end
        TX_CMD: begin
          if (cnt == CNT_W'(1)) begin
            o_sd_cmd <= crc[CRC_W-1];
            cnt      <= CNT_W'(CRC_W - 2);
            state    <= TX_CRC;
          end else begin
            o_sd_cmd <= shreg[CMD_W-1];
            cnt      <= cnt - 1'b1;
          end
        end
        TX_CRC: begin
          // CRC register is frozen here, index it directly
          o_sd_cmd <= crc[cnt[CRC_IW-1:0]];
          if (cnt == '0) begin
            state <= TX_END;
          end else begin
            cnt <= cnt - 1'b1;
          end
        end
        default: begin
          o_sd_cmd <= 1'b1;
          tx.done  <= 1'b1;
          state    <= TX_IDLE;
        end
      endcase
    end
  end

  // Controller must wait for done before the next start
  a_start_idle: assert property (@(posedge i_sd_clk) disable iff (rst)
    tx.start |-> (state == TX_IDLE));

endmodule

//--- hdl/sd_rsp_rx.sv
/*
  Response receiver for the SD CMD line
  Hunts for the start bit, captures the response and the card CRC7
  Compares the card CRC7 against its own
*/
`timescale 1ns/1ps

module sd_rsp_rx (
  input  logic     i_sd_clk,
  input  logic     rst,
  rsp_rx_if.worker rx,
  input  logic     i_sd_cmd
);
  import sd_cmd_pkg::*;

  typedef enum logic [1:0] {RX_IDLE, RX_HUNT, RX_DATA, RX_CRC} rx_state_t;

  rx_state_t        state;
  logic [CNT_W-1:0] cnt;
  logic [CRC_W-1:0] crc;
  logic [CRC_W-1:0] card_crc;
  logic [CRC_W-1:0] card_crc_next;
  logic             crc_clear;
  logic             crc_en;

  // Own CRC covers the start bit and the response bits
  assign crc_clear = (state == RX_HUNT);
  assign crc_en    = ((state == RX_HUNT) && !i_sd_cmd) || (state == RX_DATA);

  // Last card CRC bit is compared as it arrives
  assign card_crc_next = {card_crc[CRC_W-2:0], i_sd_cmd};

  sd_crc_7 u_crc (
    .i_sd_clk (i_sd_clk),
    .i_clear  (crc_clear),
    .i_en     (crc_en),
    .i_bit    (i_sd_cmd),
    .o_crc    (crc)
  );

  // Capture registers
  always_ff @(posedge i_sd_clk) begin
    if ((state == RX_IDLE) && rx.start) begin
      rx.rsp <= '0;
    end else if (state == RX_DATA) begin
      rx.rsp <= {rx.rsp[RSP_W-2:0], i_sd_cmd};
    end
    if (state == RX_CRC) begin
      card_crc <= card_crc_next;
    end
  end

  always_ff @(posedge i_sd_clk) begin
    rx.done <= 1'b0;
    if (rst) begin
      state      <= RX_IDLE;
      cnt        <= '0;
      rx.crc_err <= 1'b0;
    end else if (rx.abort) begin
      state <= RX_IDLE;
    end else begin
      case (state)
        RX_IDLE: begin
          if (rx.start) begin
            rx.crc_err <= 1'b0;
            state      <= RX_HUNT;
          end
        end
        RX_HUNT: begin
          // Card may take any number of cycles to answer
          if (!i_sd_cmd) begin
            if (rx.rsp_len != '0) begin
              cnt   <= rx.rsp_len;
              state <= RX_DATA;
            end else begin
              cnt   <= CNT_W'(CRC_W);
              state <= RX_CRC;
            end
          end
        end
        RX_DATA: begin
          if (cnt == CNT_W'(1)) begin
            cnt   <= CNT_W'(CRC_W);
            state <= RX_CRC;
          end else begin
            cnt <= cnt - 1'b1;
          end
        end
        default: begin
          if (cnt == CNT_W'(1)) begin
            rx.done    <= 1'b1;
            rx.crc_err <= (card_crc_next != crc);
            state      <= RX_IDLE;
          end else begin
            cnt <= cnt - 1'b1;
          end
        end
      endcase
    end
  end

  // One done per start, never a second one without a new start
  a_done_once: assert property (@(posedge i_sd_clk) disable iff (rst)
    rx.done |=> (!rx.done until_with rx.start));

endmodule

//--- hdl/sd_cmd_ctrl.sv
/*
  Command channel controller
  Latches the host request, runs the send and receive phases
  Owns the CMD line direction, the result outputs and abort
*/
`timescale 1ns/1ps

module sd_cmd_ctrl (
  input  logic                         i_sd_clk,
  input  logic                         rst,
  input  logic                         i_cmd_en,
  input  logic [sd_cmd_pkg::CMD_W-1:0] i_cmd,
  input  logic [sd_cmd_pkg::LEN_W-1:0] i_cmd_len,
  input  logic [sd_cmd_pkg::LEN_W-1:0] i_rsp_len,
  cmd_tx_if.ctrl                       tx,
  rsp_rx_if.ctrl                       rx,
  output logic                         o_sd_cmd_dir,
  output logic                         o_rsp_finished_en,
  output logic                         o_crc_err,
  output logic [sd_cmd_pkg::RSP_W-1:0] o_rsp
);
  import sd_cmd_pkg::*;

  cmd_state_t state;
  logic       accept;

  assign accept = (state == ST_IDLE) && i_cmd_en;

  // Request is held for the whole transfer
  always_ff @(posedge i_sd_clk) begin
    if (accept) begin
      tx.cmd     <= i_cmd;
      tx.cmd_len <= i_cmd_len;
      rx.rsp_len <= i_rsp_len;
    end
  end

  always_ff @(posedge i_sd_clk) begin
    tx.start <= 1'b0;
    rx.start <= 1'b0;
    tx.abort <= 1'b0;
    rx.abort <= 1'b0;
    if (rst) begin
      state             <= ST_IDLE;
      o_sd_cmd_dir      <= 1'b1;
      o_rsp_finished_en <= 1'b0;
      o_crc_err         <= 1'b0;
      o_rsp             <= '0;
    end else if (!i_cmd_en && (state != ST_IDLE)) begin
      // Enable dropped, pull both workers back and release nothing
      state             <= ST_IDLE;
      tx.abort          <= 1'b1;
      rx.abort          <= 1'b1;
      o_sd_cmd_dir      <= 1'b1;
      o_rsp_finished_en <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (i_cmd_en) begin
            tx.start  <= 1'b1;
            o_rsp     <= '0;
            o_crc_err <= 1'b0;
            state     <= ST_SEND;
          end
        end
        ST_SEND: begin
          // Hand the line to the card right after the end bit
          if (tx.done) begin
            o_sd_cmd_dir <= 1'b0;
            rx.start     <= 1'b1;
            state        <= ST_RECV;
          end
        end
        ST_RECV: begin
          if (rx.done) begin
            o_rsp             <= rx.rsp;
            o_crc_err         <= rx.crc_err;
            o_rsp_finished_en <= 1'b1;
            o_sd_cmd_dir      <= 1'b1;
            state             <= ST_DONE;
          end
        end
        default: begin
          // Hold results until the host drops the enable
        end
      endcase
    end
  end

  a_dir_recv: assert property (@(posedge i_sd_clk) disable iff (rst)
    (state == ST_RECV) |-> !o_sd_cmd_dir);

endmodule

//--- hdl/sd_cmd_phy.sv
/*
  SD host command channel, SD mode
  Controller, command serializer and response receiver
  Plain host and CMD line ports
*/
`timescale 1ns/1ps

module sd_cmd_phy (
  input  logic                         i_sd_clk,
  input  logic                         rst,

  // Host request and result
  input  logic                         i_cmd_en,
  input  logic [sd_cmd_pkg::CMD_W-1:0] i_cmd,
  input  logic [sd_cmd_pkg::LEN_W-1:0] i_cmd_len,
  input  logic [sd_cmd_pkg::LEN_W-1:0] i_rsp_len,
  output logic [sd_cmd_pkg::RSP_W-1:0] o_rsp,
  output logic                         o_rsp_finished_en,
  output logic                         o_crc_err,

  // CMD line, o_sd_cmd_dir high means the host drives
  input  logic                         i_sd_cmd,
  output logic                         o_sd_cmd,
  output logic                         o_sd_cmd_dir
);

  cmd_tx_if tx_if ();
  rsp_rx_if rx_if ();

  sd_cmd_ctrl u_ctrl (
    .i_sd_clk          (i_sd_clk),
    .rst               (rst),
    .i_cmd_en          (i_cmd_en),
    .i_cmd             (i_cmd),
    .i_cmd_len         (i_cmd_len),
    .i_rsp_len         (i_rsp_len),
    .tx                (tx_if),
    .rx                (rx_if),
    .o_sd_cmd_dir      (o_sd_cmd_dir),
    .o_rsp_finished_en (o_rsp_finished_en),
    .o_crc_err         (o_crc_err),
    .o_rsp             (o_rsp)
  );

  sd_cmd_tx u_tx (
    .i_sd_clk (i_sd_clk),
    .rst      (rst),
    .tx       (tx_if),
    .o_sd_cmd (o_sd_cmd)
  );

  sd_rsp_rx u_rx (
    .i_sd_clk (i_sd_clk),
    .rst      (rst),
    .rx       (rx_if),
    .i_sd_cmd (i_sd_cmd)
  );

endmodule

//--- test/sd_card_model.sv
/*
  Behavioral SD card for the command channel testbench
  Records the host command bits while the host drives the line
  Answers with start bit, response, CRC7 (good or inverted) and end bit
*/
`timescale 1ns/1ps

module sd_card_model (
  input  logic                         i_sd_clk,
  input  logic                         i_arm,
  input  logic                         i_host_cmd,
  input  logic                         i_host_dir,
  input  logic [sd_cmd_pkg::LEN_W-1:0] i_rsp_len,
  input  logic [sd_cmd_pkg::RSP_W-1:0] i_rsp,
  input  logic                         i_bad_crc,
  input  logic [7:0]                   i_delay,
  output logic                         o_card_cmd,
  output logic [63:0]                  o_cap,
  output logic [7:0]                   o_cap_cnt
);
  import sd_cmd_pkg::*;

  localparam int FR_W = RSP_W + 16;

  typedef enum logic [1:0] {C_LISTEN, C_WAIT, C_SEND, C_HOLD} card_state_t;

  card_state_t     state = C_HOLD;
  logic            line = 1'b1;
  logic [FR_W-1:0] frame;
  logic [7:0]      left;
  logic [7:0]      wait_cnt;

  assign o_card_cmd = line;

  // Reference CRC7 step, x^7 + x^3 + 1
  function automatic logic [CRC_W-1:0] crc7_step(input logic [CRC_W-1:0] crc, input logic b);
    logic fb;
    fb = b ^ crc[CRC_W-1];
    return {crc[CRC_W-2:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
  endfunction

  // Whole response frame, left aligned so the MSB goes out first
  function automatic logic [FR_W-1:0] build_frame(input logic [RSP_W-1:0] rsp,
                                                  input int len, input logic bad);
    logic [FR_W-1:0]  f;
    logic [CRC_W-1:0] crc;
    int               i;
    f   = '0;
    crc = crc7_step(7'h00, 1'b0);
    for (i = len - 1; i >= 0; i--) begin
      f   = {f[FR_W-2:0], rsp[i]};
      crc = crc7_step(crc, rsp[i]);
    end
    if (bad) begin
      crc = ~crc;
    end
    for (i = CRC_W - 1; i >= 0; i--) begin
      f = {f[FR_W-2:0], crc[i]};
    end
    f = {f[FR_W-2:0], 1'b1};
    // Start bit is the zero left in front after the shift
    return f << (FR_W - (len + 9));
  endfunction

  always @(posedge i_sd_clk) begin
    if (!i_arm) begin
      state     <= C_LISTEN;
      line      <= 1'b1;
      o_cap     <= '0;
      o_cap_cnt <= '0;
    end else begin
      case (state)
        C_LISTEN: begin
          if (i_host_dir) begin
            o_cap     <= {o_cap[62:0], i_host_cmd};
            o_cap_cnt <= o_cap_cnt + 1'b1;
          end else begin
            frame    <= build_frame(i_rsp, i_rsp_len, i_bad_crc);
            left     <= i_rsp_len + 8'd9;
            wait_cnt <= i_delay;
            state    <= C_WAIT;
          end
        end
        C_WAIT: begin
          if (wait_cnt == 8'd0) begin
            state <= C_SEND;
          end else begin
            wait_cnt <= wait_cnt - 1'b1;
          end
        end
        C_SEND: begin
          line  <= frame[FR_W-1];
          frame <= frame << 1;
          left  <= left - 1'b1;
          if (left == 8'd1) begin
            state <= C_HOLD;
          end
        end
        default: begin
          line <= 1'b1;
        end
      endcase
    end
  end

endmodule

//--- test/tb_sd_cmd_phy.sv
/*
  Testbench for the SD command channel
  Clock, reset, stimulus table applied in a loop
  Checks command bits, response, CRC flag and abort; watchdog and summary
*/
`timescale 1ns/1ps

module tb_sd_cmd_phy;
  import sd_cmd_pkg::*;

  localparam int CLK_PERIOD = 100;
  localparam int N_ROWS     = 6;
  localparam int CAP_W      = 64;

  typedef struct packed {
    logic [CMD_W-1:0] cmd;
    logic [LEN_W-1:0] cmd_len;
    logic [LEN_W-1:0] rsp_len;
    logic [RSP_W-1:0] rsp;
    logic             bad_crc;
    logic [7:0]       delay;
    logic [7:0]       abort_at;
  } test_row_t;

  test_row_t rows [N_ROWS];

  logic             sd_clk = 1'b0;
  logic             rst;
  logic             cmd_en;
  logic [CMD_W-1:0] cmd_word;
  logic [LEN_W-1:0] cmd_len;
  logic [LEN_W-1:0] rsp_len;
  logic             card_cmd;
  logic             host_cmd;
  logic             host_dir;
  logic [RSP_W-1:0] rsp;
  logic             finished;
  logic             crc_err;
  logic [RSP_W-1:0] card_rsp;
  logic             card_bad_crc;
  logic [7:0]       card_delay;
  logic [CAP_W-1:0] cap;
  logic [7:0]       cap_cnt;
  logic             table_ready = 1'b0;
  int               watchdog_cycles;
  int               pass_cnt = 0;
  int               fail_cnt = 0;

  always #(CLK_PERIOD / 2) sd_clk = ~sd_clk;

  sd_cmd_phy dut (
    .i_sd_clk          (sd_clk),
    .rst               (rst),
    .i_cmd_en          (cmd_en),
    .i_cmd             (cmd_word),
    .i_cmd_len         (cmd_len),
    .i_rsp_len         (rsp_len),
    .o_rsp             (rsp),
    .o_rsp_finished_en (finished),
    .o_crc_err         (crc_err),
    .i_sd_cmd          (card_cmd),
    .o_sd_cmd          (host_cmd),
    .o_sd_cmd_dir      (host_dir)
  );

  sd_card_model card (
    .i_sd_clk   (sd_clk),
    .i_arm      (cmd_en),
    .i_host_cmd (host_cmd),
    .i_host_dir (host_dir),
    .i_rsp_len  (rsp_len),
    .i_rsp      (card_rsp),
    .i_bad_crc  (card_bad_crc),
    .i_delay    (card_delay),
    .o_card_cmd (card_cmd),
    .o_cap      (cap),
    .o_cap_cnt  (cap_cnt)
  );

  function automatic logic [CRC_W-1:0] crc7_next(input logic [CRC_W-1:0] crc, input logic b);
    logic fb;
    fb = b ^ crc[CRC_W-1];
    return {crc[CRC_W-2:0], 1'b0} ^ (fb ? CRC7_POLY : 7'h00);
  endfunction

  // Two idle samples, the command bits, their CRC7 and the end bit
  function automatic logic [CAP_W-1:0] expected_capture(input logic [CMD_W-1:0] cmd,
                                                        input int len);
    logic [CAP_W-1:0] v;
    logic [CRC_W-1:0] crc;
    int               i;
    v   = CAP_W'(2'b11);
    crc = '0;
    for (i = CMD_W - 1; i >= CMD_W - len; i--) begin
      v   = {v[CAP_W-2:0], cmd[i]};
      crc = crc7_next(crc, cmd[i]);
    end
    for (i = CRC_W - 1; i >= 0; i--) begin
      v = {v[CAP_W-2:0], crc[i]};
    end
    return {v[CAP_W-2:0], 1'b1};
  endfunction

  task automatic set_row(input int idx, input int clen, input int rlen, input logic bad,
                         input int dly, input int abort_at);
    logic [RSP_W-1:0] r;
    r = '0;
    repeat (5) begin
      r = (r << 32) | RSP_W'($urandom);
    end
    r = r & ((RSP_W'(1) << rlen) - RSP_W'(1));
    rows[idx].cmd      = {8'($urandom), 32'($urandom)};
    rows[idx].cmd_len  = LEN_W'(clen);
    rows[idx].rsp_len  = LEN_W'(rlen);
    rows[idx].rsp      = r;
    rows[idx].bad_crc  = bad;
    rows[idx].delay    = 8'(dly);
    rows[idx].abort_at = 8'(abort_at);
  endtask

  task automatic run_row(input int idx);
    test_row_t        r;
    int               errs;
    logic [CAP_W-1:0] exp_cap;
    r       = rows[idx];
    errs    = 0;
    exp_cap = expected_capture(r.cmd, r.cmd_len);
    @(posedge sd_clk);
    cmd_en       <= 1'b1;
    cmd_word     <= r.cmd;
    cmd_len      <= r.cmd_len;
    rsp_len      <= r.rsp_len;
    card_rsp     <= r.rsp;
    card_bad_crc <= r.bad_crc;
    card_delay   <= r.delay;
    if (r.abort_at == 8'd0) begin
      @(negedge sd_clk);
      while (finished !== 1'b1) @(negedge sd_clk);
      if (rsp !== r.rsp) begin
        $display("mismatch o_rsp: got %h expected %h", rsp, r.rsp);
        errs++;
      end
      if (crc_err !== r.bad_crc) begin
        $display("mismatch o_crc_err: got %h expected %h", crc_err, r.bad_crc);
        errs++;
      end
    end else begin
      repeat (r.abort_at) @(posedge sd_clk);
      @(negedge sd_clk);
      if (finished !== 1'b0) begin
        $display("mismatch o_rsp_finished_en: got %h expected %h", finished, 1'b0);
        errs++;
      end
    end
    if (cap_cnt !== 8'(r.cmd_len + 10)) begin
      $display("mismatch o_sd_cmd_dir high cycles: got %h expected %h",
               cap_cnt, 8'(r.cmd_len + 10));
      errs++;
    end
    if (cap !== exp_cap) begin
      $display("mismatch o_sd_cmd bits: got %h expected %h", cap, exp_cap);
      errs++;
    end
    @(posedge sd_clk);
    cmd_en <= 1'b0;
    if (r.abort_at != 8'd0) begin
      // Line must be back with the host within 2 cycles
      repeat (2) @(posedge sd_clk);
      @(negedge sd_clk);
      if (host_dir !== 1'b1) begin
        $display("mismatch o_sd_cmd_dir: got %h expected %h", host_dir, 1'b1);
        errs++;
      end
      if (host_cmd !== 1'b1) begin
        $display("mismatch o_sd_cmd: got %h expected %h", host_cmd, 1'b1);
        errs++;
      end
      if (finished !== 1'b0) begin
        $display("mismatch o_rsp_finished_en: got %h expected %h", finished, 1'b0);
        errs++;
      end
    end
    @(posedge sd_clk);
    if (errs == 0) begin
      $display("test %0d: ok", idx);
      pass_cnt++;
    end else begin
      $display("test %0d: %0d errors", idx, errs);
      fail_cnt++;
    end
  endtask

  initial begin
    int i;
    void'($urandom(38025));
    rst          = 1'b1;
    cmd_en       = 1'b0;
    cmd_word     = '0;
    cmd_len      = '0;
    rsp_len      = '0;
    card_rsp     = '0;
    card_bad_crc = 1'b0;
    card_delay   = '0;
    // idx, cmd len, rsp len, bad crc, delay, abort after
    set_row(0, 40,  39, 1'b0, 0, 0);
    set_row(1, 40,  39, 1'b1, 3, 0);
    set_row(2, 40, 135, 1'b0, 1, 0);
    set_row(3, 40,  39, 1'b0, 2, 70);
    set_row(4, 40,  39, 1'b0, 5, 0);
    set_row(5, 17,   8, 1'b1, 0, 0);
    watchdog_cycles = 50;
    for (i = 0; i < N_ROWS; i++) begin
      watchdog_cycles += rows[i].cmd_len + rows[i].rsp_len + rows[i].delay + 40;
    end
    table_ready = 1'b1;
    repeat (5) @(posedge sd_clk);
    rst <= 1'b0;
    @(posedge sd_clk);
    for (i = 0; i < N_ROWS; i++) begin
      run_row(i);
    end
    $display("tests: %0d ok, %0d with errors", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  // Worst case of every row plus a margin
  initial begin
    wait (table_ready);
    repeat (watchdog_cycles) @(posedge sd_clk);
    $display("timeout: transfers did not finish within %0d cycles", watchdog_cycles);
    $display("sim failed");
    $finish;
  end

endmodule

//--- all.f
hdl/sd_cmd_pkg.sv
hdl/sd_cmd_if.sv
hdl/sd_crc_7.sv
hdl/sd_cmd_tx.sv
hdl/sd_rsp_rx.sv
hdl/sd_cmd_ctrl.sv
hdl/sd_cmd_phy.sv
test/sd_card_model.sv
test/tb_sd_cmd_phy.sv

//--- Bender.yml
package:
  name: sd_cmd_phy

sources:
  - files:
      - hdl/sd_cmd_pkg.sv
      - hdl/sd_cmd_if.sv
      - hdl/sd_crc_7.sv
      - hdl/sd_cmd_tx.sv
      - hdl/sd_rsp_rx.sv
      - hdl/sd_cmd_ctrl.sv
      - hdl/sd_cmd_phy.sv
  - target: test
    files:
      - test/sd_card_model.sv
      - test/tb_sd_cmd_phy.sv
